//--- rtc_gen_pkg.sv
// ==============================
// shared sizes, stream states and helpers for the rtc image generator
// font is 11 glyphs of 16x8 4-bit pixels, eight pixels per 32-bit word
// digit helpers expect values 0..99
// ==============================
package rtc_gen_pkg;

  localparam int font_width    = 16;                    // glyph width in pixels
  localparam int font_height   = 8;                     // glyph height in rows
  localparam int pix_per_word  = 8;
  localparam int words_per_row = font_width / pix_per_word;
  localparam int glyph_count   = 11;                    // 0..9 then colon
  localparam int colon_glyph   = 10;
  localparam int font_depth    = glyph_count * font_height * words_per_row;
  localparam int font_addr_w   = $clog2(font_depth);
  localparam int row_w         = $clog2(font_height);
  localparam int col_w         = (words_per_row > 1) ? $clog2(words_per_row) : 1;
  localparam int xfer_bytes    = font_depth * 4;        // read request size

  localparam int cs_per_sec    = 100;
  localparam int sec_per_min   = 60;
  localparam int min_per_hour  = 60;
  localparam int hour_per_day  = 24;
  localparam int cs_count_w    = 22;                    // timer period width

  typedef enum logic [3:0] {
    st_idle,
    st_hour_tens, st_hour_units, st_colon_hm,
    st_min_tens,  st_min_units,  st_colon_ms,
    st_sec_tens,  st_sec_units,  st_colon_sc,
    st_cs_tens,   st_cs_units
  } stream_state_e;

  function automatic logic [3:0] tens_digit(input logic [7:0] value);
    return 4'(value / 8'd10);
  endfunction

  function automatic logic [3:0] units_digit(input logic [7:0] value);
    return 4'(value % 8'd10);
  endfunction

  // word address of one glyph row segment
  function automatic logic [font_addr_w-1:0] glyph_addr(input logic [3:0]       glyph,
                                                        input logic [row_w-1:0] row,
                                                        input logic [col_w-1:0] col);
    return font_addr_w'(glyph * font_height * words_per_row + row * words_per_row + col);
  endfunction

endpackage

//--- rtc_kernel_ctrl.sv
// ==============================
// host job control and font load path
// gen_mode must stay stable for a whole job
// font words are always accepted, write address wraps at font_depth
// ==============================
`timescale 1ns/1ps

module rtc_kernel_ctrl import rtc_gen_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   gen_mode,
  input  logic                   ap_start,
  input  logic                   ctrl_done,
  input  logic                   frame_done,
  input  logic                   mdata_tvalid,
  input  logic [31:0]            mdata_tdata,
  output logic                   ap_idle,
  output logic                   ap_done,
  output logic                   ctrl_start,
  output logic                   start_pulse,
  output logic                   gen_go,
  output logic                   wr_en,
  output logic [font_addr_w-1:0] wr_addr,
  output logic [31:0]            wr_data
);

  logic ap_start_d;    // previous ap_start
  logic start_dly;     // start_pulse one cycle later
  logic ap_done_load;  // done of a font load job

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ap_start_d   <= 1'b0;
      start_pulse  <= 1'b0;
      start_dly    <= 1'b0;
      ctrl_start   <= 1'b0;
      ap_done_load <= 1'b0;
    end else begin
      ap_start_d   <= ap_start;
      start_pulse  <= ap_start & ~ap_start_d;  // rising edge
      start_dly    <= start_pulse;
      ctrl_start   <= start_dly & ~gen_mode;   // read request in load mode
      ap_done_load <= ctrl_done & ~gen_mode;
    end
  end

  assign gen_go  = start_dly & gen_mode;
  assign ap_done = gen_mode ? frame_done : ap_done_load;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ap_idle <= 1'b1;
    end else if (start_pulse) begin
      ap_idle <= 1'b0;
    end else if (ap_done) begin
      ap_idle <= 1'b1;
    end
  end

  // font words go straight to the buffer
  assign wr_en   = mdata_tvalid & ~gen_mode;
  assign wr_data = mdata_tdata;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      if (wr_addr == font_addr_w'(font_depth - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // request issued two cycles after the start edge, mode must not have changed
  a_no_req_in_gen: assert property (@(posedge clk) disable iff (!reset_n)
    ctrl_start |-> !gen_mode);

endmodule

//--- rtc_time_keeper.sv
// ==============================
// free running 24h clock with centisecond resolution
// cs_count must be at least 2 and stable while the clock is used
// time_set_val is loaded one cycle after the time_set_en rise, keep it stable
// ==============================
`timescale 1ns/1ps

module rtc_time_keeper import rtc_gen_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [cs_count_w-1:0] cs_count,
  input  logic [31:0]           time_set_val,
  input  logic                  time_set_en,
  input  logic                  start_pulse,
  output logic [31:0]           time_value,
  output logic [7:0]            snap_hours,
  output logic [7:0]            snap_minutes,
  output logic [7:0]            snap_seconds,
  output logic [7:0]            snap_centis
);

  logic [cs_count_w-1:0] cs_timer;
  logic                  cs_tick;     // one centisecond elapsed
  logic                  set_en_d;
  logic                  set_pulse;
  logic [6:0]            cs_cnt;
  logic [5:0]            sec_cnt;
  logic [5:0]            min_cnt;
  logic [4:0]            hour_cnt;

  assign cs_tick = (cs_timer == cs_count - 1'b1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cs_timer  <= '0;
      set_en_d  <= 1'b0;
      set_pulse <= 1'b0;
    end else begin
      cs_timer  <= cs_tick ? '0 : cs_timer + 1'b1;
      set_en_d  <= time_set_en;
      set_pulse <= time_set_en & ~set_en_d;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cs_cnt   <= '0;
      sec_cnt  <= '0;
      min_cnt  <= '0;
      hour_cnt <= '0;
    end else if (set_pulse) begin
      hour_cnt <= time_set_val[28:24];
      min_cnt  <= time_set_val[21:16];
      sec_cnt  <= time_set_val[13:8];
      cs_cnt   <= time_set_val[6:0];
    end else if (cs_tick) begin
      if (cs_cnt == 7'(cs_per_sec - 1)) begin
        cs_cnt <= '0;
        if (sec_cnt == 6'(sec_per_min - 1)) begin
          sec_cnt <= '0;
          if (min_cnt == 6'(min_per_hour - 1)) begin
            min_cnt  <= '0;
            hour_cnt <= (hour_cnt == 5'(hour_per_day - 1)) ? '0 : hour_cnt + 1'b1;
          end else begin
            min_cnt <= min_cnt + 1'b1;
          end
        end else begin
          sec_cnt <= sec_cnt + 1'b1;
        end
      end else begin
        cs_cnt <= cs_cnt + 1'b1;
      end
    end
  end

  // frame snapshot, held for the whole frame
  always_ff @(posedge clk) begin
    if (start_pulse) begin
      snap_hours   <= {3'b000, hour_cnt};
      snap_minutes <= {2'b00, min_cnt};
      snap_seconds <= {2'b00, sec_cnt};
      snap_centis  <= {1'b0, cs_cnt};
    end
  end

  // fields line up with time_set_val, upper bits zero
  assign time_value = {3'b000, hour_cnt, 2'b00, min_cnt, 2'b00, sec_cnt, 1'b0, cs_cnt};

  a_hour_range: assert property (@(posedge clk) disable iff (!reset_n)
    hour_cnt < 5'(hour_per_day));
  a_min_sec_range: assert property (@(posedge clk) disable iff (!reset_n)
    (min_cnt < 6'(min_per_hour)) && (sec_cnt < 6'(sec_per_min)));

endmodule

//--- rtc_font_buffer.sv
// ==============================
// single port font memory, font_depth words of 32 bits
// write wins over read, read data one cycle later and held otherwise
// ==============================
`timescale 1ns/1ps

module rtc_font_buffer import rtc_gen_pkg::*; (
  input  logic                   clk,
  input  logic                   wr_en,
  input  logic [font_addr_w-1:0] wr_addr,
  input  logic [31:0]            wr_data,
  input  logic                   rd_en,
  input  logic [font_addr_w-1:0] rd_addr,
  output logic [31:0]            rd_data
);

  logic [31:0] mem [font_depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // output register keeps last word
    end
  end

  // load and generate jobs never overlap
  a_single_port: assert property (@(posedge clk) wr_en |-> !rd_en);

endmodule

//--- rtc_frame_streamer.sv
// ==============================
// text frame streamer, row by row, glyph by glyph, word by word
// snap fields must be valid when gen_go arrives and stay for the frame
// show_centis must be stable during a frame
// ==============================
`timescale 1ns/1ps

module rtc_frame_streamer import rtc_gen_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   show_centis,
  input  logic                   gen_go,
  input  logic                   axis_m_tready,
  input  logic [31:0]            rd_data,
  input  logic [7:0]             snap_hours,
  input  logic [7:0]             snap_minutes,
  input  logic [7:0]             snap_seconds,
  input  logic [7:0]             snap_centis,
  output logic                   rd_en,
  output logic [font_addr_w-1:0] rd_addr,
  output logic                   axis_m_tvalid,
  output logic [63:0]            axis_m_tdata,
  output logic                   axis_m_tlast,
  output logic                   frame_done
);

  stream_state_e    state;
  stream_state_e    next_state;
  stream_state_e    last_state;     // final glyph of a row
  logic [row_w-1:0] row_cnt;
  logic [row_w-1:0] next_row;
  logic [col_w-1:0] col_cnt;
  logic [col_w-1:0] next_col;
  logic             next_tvalid;
  logic             next_done;
  logic             beat_xfer;
  logic             col_end;
  logic             row_end;
  logic [3:0]       glyph;          // glyph of the next beat

  assign last_state = show_centis ? st_cs_units : st_sec_units;
  assign beat_xfer  = axis_m_tvalid & axis_m_tready;
  assign col_end    = (col_cnt == col_w'(words_per_row - 1));
  assign row_end    = (row_cnt == row_w'(font_height - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= st_idle;
      row_cnt       <= '0;
      col_cnt       <= '0;
      axis_m_tvalid <= 1'b0;
      frame_done    <= 1'b0;
    end else begin
      state         <= next_state;
      row_cnt       <= next_row;
      col_cnt       <= next_col;
      axis_m_tvalid <= next_tvalid;
      frame_done    <= next_done;
    end
  end

  always_comb begin
    next_state  = state;
    next_row    = row_cnt;
    next_col    = col_cnt;
    next_tvalid = axis_m_tvalid;
    next_done   = 1'b0;
    rd_en       = 1'b0;
    if (state == st_idle) begin
      if (gen_go) begin
        next_state  = st_hour_tens;
        next_row    = '0;
        next_col    = '0;
        next_tvalid = 1'b1;
        rd_en       = 1'b1;  // prefetch first word
      end
    end else if (beat_xfer) begin
      if (col_end) begin
        next_col = '0;
        if (state == last_state) begin
          if (row_end) begin
            next_state  = st_idle;
            next_row    = '0;
            next_tvalid = 1'b0;
            next_done   = 1'b1;
          end else begin
            next_state = st_hour_tens;
            next_row   = row_cnt + 1'b1;
          end
        end else begin
          next_state = stream_state_e'(state + 4'd1);
        end
      end else begin
        next_col = col_cnt + 1'b1;
      end
      rd_en = next_tvalid;  // fetch only after a transfer, so data holds on a stall
    end
  end

  always_comb begin
    case (next_state)
      st_hour_tens:  glyph = tens_digit(snap_hours);
      st_hour_units: glyph = units_digit(snap_hours);
      st_min_tens:   glyph = tens_digit(snap_minutes);
      st_min_units:  glyph = units_digit(snap_minutes);
      st_sec_tens:   glyph = tens_digit(snap_seconds);
      st_sec_units:  glyph = units_digit(snap_seconds);
      st_cs_tens:    glyph = tens_digit(snap_centis);
      st_cs_units:   glyph = units_digit(snap_centis);
      st_colon_hm,
      st_colon_ms,
      st_colon_sc:   glyph = 4'(colon_glyph);
      default:       glyph = 4'd0;
    endcase
  end

  assign rd_addr = glyph_addr(glyph, next_row, next_col);

  // each 4-bit pixel becomes pixel in high nibble, ones below
  always_comb begin
    for (int i = 0; i < pix_per_word; i++) begin
      axis_m_tdata[i*8 +: 8] = {rd_data[i*4 +: 4], 4'hf};
    end
  end

  assign axis_m_tlast = axis_m_tvalid & (state == last_state) & row_end & col_end;

  a_tdata_hold: assert property (@(posedge clk) disable iff (!reset_n)
    axis_m_tvalid && !axis_m_tready |=> $stable(axis_m_tdata));

endmodule

//--- rtc_gen_core.sv
// ==============================
// rtc image generator top level
// gen_mode low loads the font, high streams one clock frame per start
// transfer size is xfer_bytes from the package
// ==============================
`timescale 1ns/1ps

module rtc_gen_core import rtc_gen_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  gen_mode,
  input  logic                  show_centis,
  input  logic [cs_count_w-1:0] cs_count,
  input  logic [31:0]           time_set_val,
  input  logic                  time_set_en,
  input  logic                  ap_start,
  output logic                  ap_idle,
  output logic                  ap_done,
  output logic                  ctrl_start,
  input  logic                  ctrl_done,
  input  logic                  mdata_tvalid,
  input  logic [31:0]           mdata_tdata,
  output logic                  axis_m_tvalid,
  input  logic                  axis_m_tready,
  output logic [63:0]           axis_m_tdata,
  output logic                  axis_m_tlast,
  output logic [31:0]           time_value
);

  logic                   start_pulse;
  logic                   gen_go;
  logic                   frame_done;
  logic                   wr_en;
  logic [font_addr_w-1:0] wr_addr;
  logic [31:0]            wr_data;
  logic                   rd_en;
  logic [font_addr_w-1:0] rd_addr;
  logic [31:0]            rd_data;
  logic [7:0]             snap_hours;
  logic [7:0]             snap_minutes;
  logic [7:0]             snap_seconds;
  logic [7:0]             snap_centis;

  rtc_kernel_ctrl u_kernel_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .gen_mode     (gen_mode),
    .ap_start     (ap_start),
    .ctrl_done    (ctrl_done),
    .frame_done   (frame_done),
    .mdata_tvalid (mdata_tvalid),
    .mdata_tdata  (mdata_tdata),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ctrl_start   (ctrl_start),
    .start_pulse  (start_pulse),
    .gen_go       (gen_go),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  rtc_time_keeper u_time_keeper (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs_count     (cs_count),
    .time_set_val (time_set_val),
    .time_set_en  (time_set_en),
    .start_pulse  (start_pulse),
    .time_value   (time_value),
    .snap_hours   (snap_hours),
    .snap_minutes (snap_minutes),
    .snap_seconds (snap_seconds),
    .snap_centis  (snap_centis)
  );

  rtc_font_buffer u_font_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  rtc_frame_streamer u_frame_streamer (
    .clk           (clk),
    .reset_n       (reset_n),
    .show_centis   (show_centis),
    .gen_go        (gen_go),
    .axis_m_tready (axis_m_tready),
    .rd_data       (rd_data),
    .snap_hours    (snap_hours),
    .snap_minutes  (snap_minutes),
    .snap_seconds  (snap_seconds),
    .snap_centis   (snap_centis),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .axis_m_tvalid (axis_m_tvalid),
    .axis_m_tdata  (axis_m_tdata),
    .axis_m_tlast  (axis_m_tlast),
    .frame_done    (frame_done)
  );

endmodule

//--- rtc_gen_checker.sv
// ==============================
// watches the rtc generator ports and checks frames and clock steps
// font image is rebuilt from the load words in address order
// counters restart on every start edge
// ==============================
`timescale 1ns/1ps

module rtc_gen_checker import rtc_gen_pkg::*; (
  input logic                  clk,
  input logic                  reset_n,
  input logic                  gen_mode,
  input logic                  show_centis,
  input logic [cs_count_w-1:0] cs_count,
  input logic [31:0]           time_set_val,
  input logic                  time_set_en,
  input logic                  ap_start,
  input logic                  ap_idle,
  input logic                  ap_done,
  input logic                  ctrl_start,
  input logic                  ctrl_done,
  input logic                  mdata_tvalid,
  input logic [31:0]           mdata_tdata,
  input logic                  axis_m_tvalid,
  input logic                  axis_m_tready,
  input logic [63:0]           axis_m_tdata,
  input logic                  axis_m_tlast,
  input logic [31:0]           time_value
);

  int          err_count = 0;
  int          beat_count = 0;
  int          last_count = 0;
  int          done_count = 0;
  int          req_count = 0;
  int          frame_beats = 0;
  int          set_wait = 0;
  int          tick_gap = 0;
  int          wr_ptr = 0;
  logic [31:0] font_img [font_depth];  // words as loaded
  logic [31:0] snapshot = '0;
  logic [31:0] tv_prev = '0;
  logic [63:0] held_data = '0;
  logic [2:0]  start_pipe = '0;       // start edge age in cycles
  logic        snap_pending = 1'b0;
  logic        start_d = 1'b0;
  logic        set_en_d = 1'b0;
  logic        frame_active = 1'b0;
  logic        hold_pending = 1'b0;
  logic        gap_valid = 1'b0;
  logic        final_xfer = 1'b0;
  logic        done_due = 1'b0;
  logic        done_seen = 1'b0;

  // expected tdata of one beat of a frame
  function automatic logic [63:0] expected_beat(input logic [31:0] snap, input logic centis,
                                                input int idx);
    int          per_row;
    int          row;
    int          rem;
    int          pos;
    int          col;
    int          value;
    int          glyph;
    logic [31:0] word;
    logic [63:0] beat;
    per_row = (centis ? 11 : 8) * 2;
    row = idx / per_row;
    rem = idx % per_row;
    pos = rem / 2;     // character position in the text
    col = rem % 2;
    case (pos / 3)
      0:       value = int'(snap[28:24]);
      1:       value = int'(snap[21:16]);
      2:       value = int'(snap[13:8]);
      default: value = int'(snap[6:0]);
    endcase
    if (pos % 3 == 2) glyph = 10;  // colon
    else if (pos % 3 == 0) glyph = value / 10;
    else glyph = value % 10;
    word = font_img[glyph * 16 + row * 2 + col];
    for (int i = 0; i < 8; i++) begin
      beat[i*8 +: 8] = {word[i*4 +: 4], 4'hf};
    end
    return beat;
  endfunction

  // one centisecond forward on a 24h clock
  function automatic logic [31:0] next_time(input logic [31:0] tv);
    int h;
    int m;
    int s;
    int c;
    h = int'(tv[28:24]);
    m = int'(tv[21:16]);
    s = int'(tv[13:8]);
    c = int'(tv[6:0]) + 1;
    if (c == 100) begin
      c = 0;
      s = s + 1;
    end
    if (s == 60) begin
      s = 0;
      m = m + 1;
    end
    if (m == 60) begin
      m = 0;
      h = h + 1;
    end
    if (h == 24) h = 0;
    return 32'((h << 24) | (m << 16) | (s << 8) | c);
  endfunction

  always @(posedge clk) begin
    if (!reset_n) begin
      tv_prev = '0;
      start_d = 1'b0;
      set_en_d = 1'b0;
      set_wait = 0;
      tick_gap = 0;
      gap_valid = 1'b0;
      wr_ptr = 0;
      start_pipe = '0;
      done_due = 1'b0;
      done_seen = 1'b0;
    end else begin
      if (snap_pending) snapshot = time_value;  // same edge the DUT latches
      snap_pending = 1'b0;
      final_xfer = 1'b0;
      if (start_pipe[1] && ap_idle !== 1'b0) begin
        $display("ERROR ap_idle after start: got %h expected %h", ap_idle, 1'b0);
        err_count++;
      end
      if (ctrl_start !== (start_pipe[2] & ~gen_mode)) begin
        $display("ERROR ctrl_start: got %h expected %h", ctrl_start,
                 start_pipe[2] & ~gen_mode);
        err_count++;
      end
      if (start_pipe[2] && gen_mode && axis_m_tvalid !== 1'b1) begin
        $display("ERROR axis_m_tvalid after start: got %h expected %h", axis_m_tvalid, 1'b1);
        err_count++;
      end
      if (ap_done !== done_due) begin
        $display("ERROR ap_done: got %h expected %h", ap_done, done_due);
        err_count++;
      end
      if (done_seen && ap_idle !== 1'b1) begin
        $display("ERROR ap_idle after done: got %h expected %h", ap_idle, 1'b1);
        err_count++;
      end
      done_seen = ap_done;
      if (mdata_tvalid && !gen_mode) begin
        font_img[wr_ptr] = mdata_tdata;
        wr_ptr = (wr_ptr + 1) % font_depth;
      end
      if (ap_start && !start_d) begin
        beat_count = 0;
        last_count = 0;
        done_count = 0;
        req_count = 0;
        snap_pending = 1'b1;
        hold_pending = 1'b0;
        frame_active = gen_mode;
        frame_beats = font_height * (show_centis ? 11 : 8) * words_per_row;
      end
      if (axis_m_tvalid) begin
        if (!frame_active) begin
          $display("ERROR stream: tvalid high outside a frame");
          err_count++;
        end
        if (hold_pending && axis_m_tdata !== held_data) begin
          $display("ERROR axis_m_tdata hold: got %h expected %h", axis_m_tdata, held_data);
          err_count++;
        end
        if (axis_m_tready) begin
          if (axis_m_tdata !== expected_beat(snapshot, show_centis, beat_count)) begin
            $display("ERROR axis_m_tdata beat %0d: got %h expected %h", beat_count,
                     axis_m_tdata, expected_beat(snapshot, show_centis, beat_count));
            err_count++;
          end
          if (axis_m_tlast !== (beat_count == frame_beats - 1)) begin
            $display("ERROR axis_m_tlast beat %0d: got %h expected %h", beat_count,
                     axis_m_tlast, (beat_count == frame_beats - 1));
            err_count++;
          end
          last_count += int'(axis_m_tlast);
          beat_count++;
          final_xfer = (beat_count == frame_beats);
          if (beat_count >= frame_beats) frame_active = 1'b0;
          hold_pending = 1'b0;
        end else begin
          hold_pending = 1'b1;
          held_data = axis_m_tdata;
        end
      end else begin
        hold_pending = 1'b0;
      end
      done_due = gen_mode ? final_xfer : ctrl_done;
      done_count += int'(ap_done);
      req_count += int'(ctrl_start);
      tick_gap++;
      if (set_wait > 0) begin
        set_wait--;  // load in flight
        gap_valid = 1'b0;
        if (set_wait == 0 && time_value !== time_set_val) begin
          $display("ERROR time_value after set: got %h expected %h", time_value,
                   time_set_val);
          err_count++;
        end
      end else if (time_value !== tv_prev) begin
        if (time_value !== next_time(tv_prev)) begin
          $display("ERROR time_value: got %h expected %h", time_value, next_time(tv_prev));
          err_count++;
        end else if (gap_valid && tick_gap != int'(cs_count)) begin
          $display("ERROR time_value step period: got %h expected %h", tick_gap, cs_count);
          err_count++;
        end
        gap_valid = 1'b1;
        tick_gap = 0;
      end
      if (time_set_en && !set_en_d) set_wait = 2;
      tv_prev = time_value;
      start_pipe = {start_pipe[1:0], ap_start & ~start_d};
      start_d = ap_start;
      set_en_d = time_set_en;
    end
  end

endmodule

//--- rtc_gen_tb.sv
// ==============================
// testbench for the rtc image generator
// loads the font, sets the clock, then streams two frames
// cs_count is 4 for the whole run
// ==============================
`timescale 1ns/1ps

module rtc_gen_tb;

  logic        clk;
  logic        reset_n;
  logic        gen_mode;
  logic        show_centis;
  logic [21:0] cs_count;
  logic [31:0] time_set_val;
  logic        time_set_en;
  logic        ap_start;
  logic        ap_idle;
  logic        ap_done;
  logic        ctrl_start;
  logic        ctrl_done;
  logic        mdata_tvalid;
  logic [31:0] mdata_tdata;
  logic        axis_m_tvalid;
  logic        axis_m_tready;
  logic [63:0] axis_m_tdata;
  logic        axis_m_tlast;
  logic [31:0] time_value;

  integer      seed = 32'h9f62c3c1;
  logic [31:0] rnd;
  int          fail_count = 0;
  int          tests_failed = 0;
  int          tests_run = 0;
  int          err_start;
  int          fail_start;
  int          n;

  rtc_gen_core u_dut (.*);
  rtc_gen_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic start_job();
    ap_start = 1'b1;
    step();
    ap_start = 1'b0;
    step();
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      fail_count++;
    end
  endtask

  task automatic wait_done(input int limit);
    n = 0;
    while (ap_done !== 1'b1 && n < limit) begin
      step();
      n++;
    end
    if (n >= limit) begin
      $display("timeout: ap_done never pulsed");
      fail_count++;
    end
  endtask

  task automatic open_test();
    err_start = u_checker.err_count;
    fail_start = fail_count;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (u_checker.err_count != err_start || fail_count != fail_start) begin
      tests_failed++;
      $display("test %s: FAIL", name);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  initial begin
    reset_n = 1'b0;
    gen_mode = 1'b0;
    show_centis = 1'b0;
    cs_count = 22'd4;
    time_set_val = '0;
    time_set_en = 1'b0;
    ap_start = 1'b0;
    ctrl_done = 1'b0;
    mdata_tvalid = 1'b0;
    mdata_tdata = '0;
    axis_m_tready = 1'b1;
    repeat (3) step();

    open_test();
    expect_value("ap_idle", 32'(ap_idle), 32'h1);
    expect_value("ap_done", 32'(ap_done), 32'h0);
    expect_value("ctrl_start", 32'(ctrl_start), 32'h0);
    expect_value("axis_m_tvalid", 32'(axis_m_tvalid), 32'h0);
    expect_value("time_value", time_value, 32'h0);
    close_test("reset state");
    reset_n = 1'b1;
    step();

    open_test();
    start_job();
    n = 0;
    while (ctrl_start !== 1'b1 && n < 20) begin
      step();
      n++;
    end
    if (n >= 20) begin
      $display("timeout: ctrl_start never pulsed");
      fail_count++;
    end
    for (int a = 0; a < rtc_gen_pkg::xfer_bytes / 4; a++) begin
      mdata_tvalid = 1'b1;
      mdata_tdata = 32'(a) * 32'h9e3779b1 + 32'h13579bdf;
      step();
    end
    mdata_tvalid = 1'b0;
    step();
    ctrl_done = 1'b1;
    step();
    ctrl_done = 1'b0;
    wait_done(20);
    n = 0;
    while (ap_idle !== 1'b1 && n < 20) begin
      step();
      n++;
    end
    if (n >= 20) begin
      $display("timeout: ap_idle did not return after the font load");
      fail_count++;
    end
    step();
    expect_value("ctrl_start pulses", 32'(u_checker.req_count), 32'h1);
    expect_value("ap_done pulses", 32'(u_checker.done_count), 32'h1);
    close_test("font load");

    open_test();
    time_set_val = {8'd23, 8'd59, 8'd59, 8'd98};
    time_set_en = 1'b1;
    step();
    step();
    time_set_en = 1'b0;
    n = 0;
    while (time_value !== time_set_val && n < 10) begin
      step();
      n++;
    end
    if (n >= 10) begin
      $display("timeout: set time never appeared on time_value");
      fail_count++;
    end
    n = 0;
    while (time_value !== 32'h0 && n < 30) begin
      step();
      n++;
    end
    if (n >= 30) begin
      $display("timeout: clock did not wrap to midnight");
      fail_count++;
    end
    close_test("clock set and rollover");

    open_test();
    gen_mode = 1'b1;
    show_centis = 1'b0;
    axis_m_tready = 1'b1;
    step();
    start_job();
    wait_done(1000);
    step();
    step();
    expect_value("beats", 32'(u_checker.beat_count), 32'd128);
    expect_value("tlast beats", 32'(u_checker.last_count), 32'h1);
    expect_value("ap_done pulses", 32'(u_checker.done_count), 32'h1);
    close_test("frame hh:mm:ss");

    open_test();
    show_centis = 1'b1;
    step();
    start_job();
    n = 0;
    while (ap_done !== 1'b1 && n < 3000) begin
      rnd = $random(seed);
      axis_m_tready = rnd[0];  // about half the cycles stalled
      step();
      n++;
    end
    if (n >= 3000) begin
      $display("timeout: frame with centiseconds never finished");
      fail_count++;
    end
    axis_m_tready = 1'b1;
    step();
    step();
    expect_value("beats", 32'(u_checker.beat_count), 32'd176);
    expect_value("tlast beats", 32'(u_checker.last_count), 32'h1);
    expect_value("ap_done pulses", 32'(u_checker.done_count), 32'h1);
    close_test("frame hh:mm:ss:cc with back-pressure");

    $display("tests run %0d, failed %0d, checker errors %0d", tests_run, tests_failed,
             u_checker.err_count);
    if (tests_failed == 0 && fail_count == 0 && u_checker.err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rtc_gen.f
rtc_gen_pkg.sv
rtc_kernel_ctrl.sv
rtc_time_keeper.sv
rtc_font_buffer.sv
rtc_frame_streamer.sv
rtc_gen_core.sv
rtc_gen_checker.sv
rtc_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rtc generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f rtc_gen.f --top-module rtc_gen_tb \
  -o rtc_gen_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rtc_gen_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
